// ==== rtl/cpuPkg.sv ====
// Word width, register count and opcodes are fixed by the 16-bit encoding and are not tunable
`default_nettype none

package cpuPkg;

    // Instruction ROM depth in 16-bit words
    localparam int ROM_WORDS = 256;

    // One data word: PC, registers, ALU and bus values
    typedef logic [15:0] word_t;

    // Register index, eight registers
    typedef logic [2:0] regAddr_t;

    // JAL writes its return address here
    localparam regAddr_t LINK_REG = 3'd7;

    // Major opcode at instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        // R-format, function in instr[1:0]
        OP_RALU  = 5'b11011
    } opcode_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_SLBI} aluOp_t;

    // Immediate field width and extension kind
    typedef enum logic [2:0] {IMM5_SIGN, IMM5_ZERO, IMM8_SIGN, IMM8_ZERO, IMM11_SIGN} immSel_t;

    // Write-back source
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wbSel_t;

endpackage

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
// Program is read from prog.hex at elaboration; PC bits above the ROM depth are ignored
`default_nettype none

module fetchUnit import cpuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  haltReq,
    input  logic  branchTaken,
    input  word_t branchOffset,
    input  logic  jumpReg,
    input  word_t jumpTarget,
    output word_t instr,
    output word_t pcPlus2,
    output logic  halted
);

    word_t rom [ROM_WORDS];
    word_t pc;
    word_t nextPc;
    logic [$clog2(ROM_WORDS)-1:0] romIdx;

    initial begin
        $readmemh("prog.hex", rom);
    end

    // Byte PC to word index, bit 0 dropped
    assign romIdx = pc[$clog2(ROM_WORDS):1];
    assign instr = rom[romIdx];
    assign pcPlus2 = pc + 16'd2;

    // JR wins over relative targets
    always_comb begin
        if (jumpReg) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            // Offsets are relative to the following instruction
            nextPc = pcPlus2 + branchOffset;
        end else begin
            nextPc = pcPlus2;
        end
    end

    // PC frozen on stall, on HALT and forever after
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall && !halted && !haltReq) begin
            pc <= nextPc;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (haltReq && !stall) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decodeControl.sv ====
// Unlisted opcodes decode as NOP; LD takes its base register from instr[7:5], not instr[10:8]
`default_nettype none

module decodeControl import cpuPkg::*; (
    input  word_t    instr,
    output regAddr_t rsAddr,
    output regAddr_t rtAddr,
    output regAddr_t rdAddr,
    output word_t    imm,
    output aluOp_t   aluOp,
    output logic     aluSrcImm,
    output logic     regWrite,
    output wbSel_t   wbSel,
    output logic     memRead,
    output logic     memWrite,
    output logic     branchEq,
    output logic     branchNe,
    output logic     jump,
    output logic     jumpReg,
    output logic     haltReq
);

    opcode_t    opcode;
    immSel_t    immSel;
    logic [1:0] func;

    assign opcode = opcode_t'(instr[15:11]);
    assign func = instr[1:0];

    // Rt slot also carries ST data
    assign rtAddr = instr[7:5];
    // LD keeps its destination in [10:8], so the base moves down
    assign rsAddr = (opcode == OP_LD) ? instr[7:5] : instr[10:8];

    always_comb begin
        // NOP defaults
        rdAddr = instr[7:5];
        immSel = IMM5_SIGN;
        aluOp = ALU_ADD;
        aluSrcImm = 1'b0;
        regWrite = 1'b0;
        wbSel = WB_ALU;
        memRead = 1'b0;
        memWrite = 1'b0;
        branchEq = 1'b0;
        branchNe = 1'b0;
        jump = 1'b0;
        jumpReg = 1'b0;
        haltReq = 1'b0;
        case (opcode)
            OP_HALT: begin
                haltReq = 1'b1;
            end
            OP_RALU: begin
                rdAddr = instr[4:2];
                regWrite = 1'b1;
                case (func)
                    2'b00: aluOp = ALU_ADD;
                    2'b01: aluOp = ALU_SUB;
                    2'b10: aluOp = ALU_XOR;
                    default: aluOp = ALU_ANDN;
                endcase
            end
            OP_ADDI, OP_SUBI: begin
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                aluOp = (opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
            end
            OP_XORI, OP_ANDNI: begin
                // Logic immediates are zero extended
                immSel = IMM5_ZERO;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                aluOp = (opcode == OP_XORI) ? ALU_XOR : ALU_ANDN;
            end
            OP_LBI: begin
                // ADD against a zeroed A operand, see cpuTop
                rdAddr = instr[10:8];
                immSel = IMM8_SIGN;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
            end
            OP_SLBI: begin
                rdAddr = instr[10:8];
                immSel = IMM8_ZERO;
                aluOp = ALU_SLBI;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
            end
            OP_ST: begin
                aluSrcImm = 1'b1;
                memWrite = 1'b1;
            end
            OP_LD: begin
                rdAddr = instr[10:8];
                aluSrcImm = 1'b1;
                memRead = 1'b1;
                regWrite = 1'b1;
                wbSel = WB_LOAD;
            end
            OP_BEQZ: begin
                immSel = IMM8_SIGN;
                branchEq = 1'b1;
            end
            OP_BNEZ: begin
                immSel = IMM8_SIGN;
                branchNe = 1'b1;
            end
            OP_J: begin
                immSel = IMM11_SIGN;
                jump = 1'b1;
            end
            OP_JAL: begin
                immSel = IMM11_SIGN;
                jump = 1'b1;
                rdAddr = LINK_REG;
                regWrite = 1'b1;
                wbSel = WB_LINK;
            end
            OP_JR: begin
                // Target is Rs plus signed 8-bit displacement
                immSel = IMM8_SIGN;
                aluSrcImm = 1'b1;
                jumpReg = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Immediate extender
    always_comb begin
        case (immSel)
            IMM5_SIGN: imm = {{11{instr[4]}}, instr[4:0]};
            IMM5_ZERO: imm = {11'd0, instr[4:0]};
            IMM8_SIGN: imm = {{8{instr[7]}}, instr[7:0]};
            IMM8_ZERO: imm = {8'd0, instr[7:0]};
            default: imm = {{5{instr[10]}}, instr[10:0]};
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// No read bypass: a read in the same cycle as a write returns the old value
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    input  logic     writeEn,
    output word_t    rsData,
    output word_t    rtData
);

    // One entry per index value
    word_t regs [2**$bits(regAddr_t)];

    // Combinational read ports
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

    // Single write port, all registers cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**$bits(regAddr_t); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// No carry, overflow or shift outputs; zero reflects operand a, not the result
`default_nettype none

module alu import cpuPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result,
    output logic   zero
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                // Reversed operands, Rd = Rt - Rs and Rd = I - Rs
                result = b - a;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_ANDN: begin
                result = a & ~b;
            end
            ALU_SLBI: begin
                // Low byte moves up, immediate fills the bottom
                result = {a[7:0], 8'h00} | b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    // BEQZ and BNEZ test Rs, which always sits on a
    assign zero = (a == '0);

endmodule

`default_nettype wire

// ==== rtl/dataBusMaster.sv ====
// One Wishbone classic transfer at a time, word aligned, no error or retry handling
`default_nettype none

module dataBusMaster import cpuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  memRead,
    input  logic  memWrite,
    input  word_t addr,
    input  word_t storeData,
    output word_t loadData,
    output logic  stall,
    output logic  wbCyc,
    output logic  wbStb,
    output logic  wbWe,
    output word_t wbAdr,
    output word_t wbWriteData,
    input  word_t wbReadData,
    input  logic  wbAck
);

    typedef enum logic {IDLE, BUSY} busState_t;

    busState_t state;
    logic      memReq;

    assign memReq = memRead | memWrite;

    // Hold the core until the ack edge of its own transfer
    assign stall = memReq && !(state == BUSY && wbAck);

    // Sampled by the register file on the ack edge
    assign loadData = wbReadData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (memReq) begin
                        state <= BUSY;
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        wbWe <= memWrite;
                    end
                end
                default: begin
                    // Cycle ends on the same edge that sees ack
                    if (wbAck) begin
                        state <= IDLE;
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        wbWe <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Address and data held steady for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && memReq) begin
            wbAdr <= {addr[15:1], 1'b0};
            wbWriteData <= storeData;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpuTop.sv ====
// Single-cycle core; only LD and ST stall, and halted is cleared by reset alone
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    output logic  wbCyc,
    output logic  wbStb,
    output logic  wbWe,
    output word_t wbAdr,
    output word_t wbWriteData,
    input  word_t wbReadData,
    input  logic  wbAck,
    output logic  halted
);

    word_t    instr, pcPlus2, imm;
    word_t    rsData, rtData;
    word_t    aluA, aluB, aluResult;
    word_t    loadData, writeData;
    regAddr_t rsAddr, rtAddr, rdAddr;
    aluOp_t   aluOp;
    wbSel_t   wbSel;
    opcode_t  opcode;
    logic     aluSrcImm, regWrite, memRead, memWrite;
    logic     branchEq, branchNe, jump, jumpReg, haltReq;
    logic     zero, stall, branchTaken;

    // Input side
    fetchUnit uFetch (
        .clk(clk), .rst(rst), .stall(stall), .haltReq(haltReq),
        .branchTaken(branchTaken), .branchOffset(imm),
        .jumpReg(jumpReg), .jumpTarget(aluResult),
        .instr(instr), .pcPlus2(pcPlus2), .halted(halted)
    );

    decodeControl uDecode (
        .instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(rdAddr), .imm(imm),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .regWrite(regWrite), .wbSel(wbSel),
        .memRead(memRead), .memWrite(memWrite), .branchEq(branchEq), .branchNe(branchNe),
        .jump(jump), .jumpReg(jumpReg), .haltReq(haltReq)
    );

    // Writes held off while the bus transfer is pending
    regFile uRegs (
        .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .writeAddr(rdAddr), .writeData(writeData), .writeEn(regWrite && !stall),
        .rsData(rsData), .rtData(rtData)
    );

    // LBI loads the bare immediate
    assign opcode = opcode_t'(instr[15:11]);
    assign aluA = (opcode == OP_LBI) ? '0 : rsData;
    assign aluB = aluSrcImm ? imm : rtData;

    alu uAlu (
        .a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(zero)
    );

    // Taken conditional branch, or J and JAL
    assign branchTaken = (branchEq && zero) || (branchNe && !zero) || jump;

    // Output side, effective address from the ALU, store data from Rt
    dataBusMaster uBus (
        .clk(clk), .rst(rst), .memRead(memRead), .memWrite(memWrite),
        .addr(aluResult), .storeData(rtData), .loadData(loadData), .stall(stall),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbWriteData(wbWriteData), .wbReadData(wbReadData), .wbAck(wbAck)
    );

    // Write-back select
    always_comb begin
        case (wbSel)
            WB_LOAD: writeData = loadData;
            WB_LINK: writeData = pcPlus2;
            default: writeData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb/cpuWb_chk.sv ====
// Assumes one master on the bus and a slave that pulses wbAck for one cycle per transfer
`default_nettype none

module cpuWb_chk import cpuPkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  wbCyc,
    input logic  wbStb,
    input logic  wbWe,
    input word_t wbAdr,
    input word_t wbWriteData,
    input logic  wbAck,
    input logic  halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // Read back by the testbench for its closing report
    int failCount = 0;

    // Strobe only ever inside a cycle
    stbInCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else begin
            failCount++;
            $error("wbStb high while wbCyc low");
        end

    // Request frozen through wait states
    reqStable: assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbWriteData))
        else begin
            failCount++;
            $error("address, write enable or data changed before ack");
        end

    // Bus idle and core running right out of reset
    resetIdle: assert property (@(posedge clk) rst |=> !wbCyc && !wbStb && !wbWe && !halted)
        else begin
            failCount++;
            $error("bus or halt flag active after reset");
        end

    // Halt is sticky
    haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped without reset");
        end

    // No bus cycle once halted
    haltQuiet: assert property (@(posedge clk) disable iff (rst) halted |-> !wbCyc)
        else begin
            failCount++;
            $error("bus cycle started after halt");
        end

endmodule

`default_nettype wire

// ==== tb/tbCpu.sv ====
// Expected stores follow the layout of prog.hex and the slave decodes only byte address bits 7:1
`default_nettype none

module tbCpu import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 50;
    // Ample room for about 60 instructions of up to 5 cycles each plus reset and idle
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MEM_WORDS = 128;
    // Preloaded words for byte addresses 0x40 to 0x46
    localparam word_t PRELOAD [4] = '{16'h3C5A, 16'h0101, 16'h7FF0, 16'h8421};

    logic  clk;
    logic  rst;
    logic  wbCyc, wbStb, wbWe, wbAck, halted;
    word_t wbAdr, wbWriteData, wbReadData;

    word_t mem [MEM_WORDS];
    word_t expAddrQ [$];
    word_t expDataQ [$];
    int    seed = 32'h093fc8c0;
    int    errors = 0;
    int    cycleCount = 0;

    cpuTop DUT (
        .clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbWriteData(wbWriteData), .wbReadData(wbReadData),
        .wbAck(wbAck), .halted(halted)
    );

    bind cpuTop cpuWb_chk uChk (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Background pattern from the full word index
    task automatic fillMemory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (word_t'(i) * 16'h0203) ^ 16'hA5C3;
        end
        for (int i = 0; i < 4; i++) begin
            mem[16'h20 + i] = PRELOAD[i];
        end
    endtask

    task automatic expectStore(input word_t addr, input word_t data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    // Stores in program order with r2 = 0x1234 and r3 = 0x5A for the first eight
    task automatic loadExpected();
        expectStore(16'h0050, 16'h1234 + 16'h005A);
        // SUB takes Rt minus Rs
        expectStore(16'h0052, 16'h005A - 16'h1234);
        expectStore(16'h0054, 16'h1234 ^ 16'h005A);
        expectStore(16'h0056, 16'h1234 & ~16'h005A);
        expectStore(16'h0058, 16'h1234 + 16'hFFFD);
        expectStore(16'h005A, 16'h0007 - 16'h1234);
        // Logic immediates zero extended
        expectStore(16'h005C, 16'h1234 ^ 16'h001F);
        expectStore(16'h005E, 16'h1234 & ~16'h0014);
        expectStore(16'h004E, 16'hFF80);
        expectStore(16'h0048, PRELOAD[0] + PRELOAD[1]);
        expectStore(16'h004A, PRELOAD[1] - PRELOAD[0]);
        expectStore(16'h004C, PRELOAD[2] + PRELOAD[3]);
        // Branch markers on the taken path only
        expectStore(16'h0050, 16'h0011);
        expectStore(16'h0050, 16'h0022);
        expectStore(16'h0050, 16'h0033);
        expectStore(16'h0050, 16'h0044);
        expectStore(16'h0050, 16'h0066);
        // Link from JAL at byte 0x66 is the next word address
        expectStore(16'h0050, 16'h0068);
    endtask

    // Raises ack for one cycle after the wait states
    task automatic serveTransfer();
        word_t expAddr;
        word_t expData;
        if (wbWe) begin
            mem[wbAdr[7:1]] = wbWriteData;
            if (expAddrQ.size() == 0) begin
                errors++;
                $display("unexpected store of %h to %h at %0t", wbWriteData, wbAdr, $time);
            end else begin
                expAddr = expAddrQ.pop_front();
                expData = expDataQ.pop_front();
                if (expAddr !== wbAdr || expData !== wbWriteData) begin
                    errors++;
                    $display("mismatch at %0t: expected %h <= %h, got %h <= %h",
                             $time, expAddr, expData, wbAdr, wbWriteData);
                end
            end
        end
        wbReadData = mem[wbAdr[7:1]];
        wbAck = 1'b1;
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    initial begin : slaveSeq
        int waits;
        forever begin
            @(posedge clk);
            #0.5;
            wbAck = 1'b0;
            if (wbCyc && wbStb) begin
                waits = $unsigned($random(seed)) % 4;
                repeat (waits) begin
                    @(posedge clk);
                    #0.5;
                end
                serveTransfer();
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : mainSeq
        rst = 1'b1;
        wbAck = 1'b0;
        wbReadData = '0;
        fillMemory();
        loadExpected();
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;
        wait (halted === 1'b1);
        if (expAddrQ.size() != 0) begin
            errors++;
            $display("core halted with %0d expected stores never seen", expAddrQ.size());
        end
        // Bus must stay quiet while halted
        repeat (IDLE_CYCLES) @(posedge clk);
        #0.5;
        $display("errors: %0d store checks, %0d assertions", errors, DUT.uChk.failCount);
        if (errors == 0 && DUT.uChk.failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/decodeControl.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataBusMaster.sv
rtl/cpuTop.sv
tb/cpuWb_chk.sv
tb/tbCpu.sv

// ==== prog.hex ====
// Columns: 16-bit instruction words in hex, ROM word 0 first, several words per line
// Store base r1 = 0x50; memory words 0x40..0x46 are preloaded by the testbench
C150 C212 9234 C35A  // LBI r1 0x50, LBI r2 0x12, SLBI r2 0x34, LBI r3 0x5A
DA70 DA75 DA7A DA7F  // ADD r4, SUB r5, XOR r6, ANDN r7 from r2 and r3
8180 81A2 81C4 81E6  // ST r4..r7 to 0x50..0x56
429D 4AA7 52DF 5AF4  // ADDI -3, SUBI 7, XORI 0x1F, ANDNI 0x14 on r2
8188 81AA 81CC 81EE  // ST r4..r7 to 0x58..0x5E
C480 819E            // LBI r4 0x80 (negative), ST to 0x4E
8A30 8B32 DA70 DA75  // LD 0x40 and 0x42, then sum and difference
8A34 8B36 DA78       // LD 0x44 and 0x46, then sum
8198 81BA 81DC       // ST sum, difference, second sum to 0x48..0x4C
6004 C5EE 81A0 C511 81A0  // BEQZ r0 taken over poison, marker 0x11
6304 C522 81A0            // BEQZ r3 not taken, marker 0x22
6B04 C5EE 81A0 C533 81A0  // BNEZ r3 taken over poison, marker 0x33
6804 C544 81A0            // BNEZ r0 not taken, marker 0x44
2004 C5EE 81A0            // J over poison
3004 81E0 0000            // JAL to subroutine at 0x6C, ST r7 after return, HALT
C566 81A0 2F00            // Subroutine: marker 0x66, JR r7
